//--- list.f
lsu_pkg.sv
sram_if.sv
scratchpad_ram.sv
row_extract.sv
lsu_ctrl.sv
lsu.sv
lsu_sva.sv
tb_lsu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f list.f -o sim_lsu

# the log decides the result, so a nonzero simulator exit is not fatal here
./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

//--- tb_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu;

    typedef struct packed {
        lsu_pkg::lsu_op_e                 op;
        logic [3:0]                       sx;
        logic [lsu_pkg::ROW_IDX_W-1:0]    sy;
        logic [lsu_pkg::ELEM_CNT_W-1:0]   ec;
        logic [lsu_pkg::BYTE_ADDR_W-1:0]  ba;
        logic [lsu_pkg::COUNT_W-1:0]      cnt;
    } instr_t;

    localparam int NUM_TESTS   = 13;
    localparam int CLK_PERIOD  = 20;
    localparam int WATCHDOG_NS = (NUM_TESTS * 300 + 100) * CLK_PERIOD;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             instr_vld;
    logic                             instr_rdy;
    lsu_pkg::lsu_op_e                 op;
    logic [3:0]                       start_x;
    logic [lsu_pkg::ROW_IDX_W-1:0]    start_y;
    logic [lsu_pkg::ELEM_CNT_W-1:0]   elem_cnt;
    logic [lsu_pkg::BYTE_ADDR_W-1:0]  byte_addr;
    logic [lsu_pkg::COUNT_W-1:0]      count;
    lsu_pkg::row_bank_t               mxu_rows;
    logic                             mxu_data_rdy;
    logic                             feed_vld;
    logic                             feed_rdy;
    lsu_pkg::row_t                    feed_data;

    instr_t         tests [NUM_TESTS];
    lsu_pkg::row_t  iram_model [lsu_pkg::RAM_DEPTH];
    lsu_pkg::row_t  wram_model [lsu_pkg::RAM_DEPTH];
    logic [31:0]    lfsr = 32'h26d;
    int             checks = 0;
    int             mismatches = 0;
    int             other_errs = 0;

    lsu lsu_inst (.*);

    bind lsu_ctrl lsu_sva ctrl_checks (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_rdy (instr_rdy),
        .state     (state),
        .feed_vld  (feed_vld),
        .feed_rdy  (feed_rdy),
        .feed_data (feed_data),
        .iram_ce   (iram_port.ce),
        .iram_we   (iram_port.we),
        .wram_ce   (wram_port.ce),
        .wram_we   (wram_port.we)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic next_rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return lsb;
    endfunction

    // element i takes column sx+i inside the window and zero outside it
    function automatic lsu_pkg::row_t masked_row(lsu_pkg::row_t src, int sx, int ec);
        lsu_pkg::row_t w;
        w = '0;
        for (int i = 0; i < lsu_pkg::ROW_ELEMS; i++) begin
            if (i < ec && sx + i < lsu_pkg::ROW_ELEMS) begin
                w[i*lsu_pkg::ELEM_W +: lsu_pkg::ELEM_W] =
                    src[(sx+i)*lsu_pkg::ELEM_W +: lsu_pkg::ELEM_W];
            end
        end
        return w;
    endfunction

    // rising edge with fresh random back-pressure
    task automatic next_edge();
        @(posedge clk);
        feed_rdy     <= next_rand_bit();
        mxu_data_rdy <= next_rand_bit();
    endtask

    task automatic run_instr(input instr_t cur, input int tnum);
        lsu_pkg::row_bank_t bank;
        lsu_pkg::row_t      want;
        logic [7:0]         base;
        logic [7:0]         a;
        int                 got;
        int                 rdy_cycles;
        bit                 is_store;
        base     = cur.ba[lsu_pkg::BYTE_ADDR_W-1 -: lsu_pkg::RAM_ADDR_W];
        is_store = (cur.op == lsu_pkg::OP_ST_IRAM) || (cur.op == lsu_pkg::OP_ST_WRAM);
        bank     = '0;
        if (is_store) begin
            for (int r = 0; r < lsu_pkg::NUM_ROWS; r++) begin
                for (int b = 0; b < lsu_pkg::ROW_W; b++) begin
                    bank[r][b] = next_rand_bit();
                end
            end
        end
        next_edge();
        instr_vld <= 1'b1;
        op        <= cur.op;
        start_x   <= cur.sx;
        start_y   <= cur.sy;
        elem_cnt  <= cur.ec;
        byte_addr <= cur.ba;
        count     <= cur.cnt;
        if (is_store) begin
            mxu_rows <= bank;
        end
        @(negedge clk);
        while (!instr_rdy) begin
            next_edge();
            @(negedge clk);
        end
        next_edge();
        instr_vld <= 1'b0;
        if (is_store) begin
            for (int k = 0; k < int'(cur.cnt); k++) begin
                a    = base + 8'(k);
                want = masked_row(bank[(int'(cur.sy) + k) % 16], cur.sx, cur.ec);
                if (cur.op == lsu_pkg::OP_ST_IRAM) begin
                    iram_model[a] = want;
                end else begin
                    wram_model[a] = want;
                end
            end
        end
        got        = 0;
        rdy_cycles = 0;
        @(negedge clk);
        while (!instr_rdy) begin
            // each ready cycle of a store is one word written
            if (is_store && mxu_data_rdy) begin
                rdy_cycles++;
            end
            if (!is_store && feed_vld && feed_rdy) begin
                a    = base + 8'(got);
                want = (cur.op == lsu_pkg::OP_FEED_IRAM) ? iram_model[a] : wram_model[a];
                checks++;
                if (got >= int'(cur.cnt)) begin
                    other_errs++;
                    $display("instr %0d: feed sent more than %0d words", tnum, cur.cnt);
                end else if (feed_data !== want) begin
                    mismatches++;
                    $display("MISMATCH feed_data instr %0d word %0d: got %h expected %h",
                             tnum, got, feed_data, want);
                end
                got++;
            end
            next_edge();
            @(negedge clk);
        end
        if (is_store) begin
            checks++;
            if (rdy_cycles != int'(cur.cnt)) begin
                other_errs++;
                $display("instr %0d: store ended after %0d ready cycles for %0d words",
                         tnum, rdy_cycles, cur.cnt);
            end
        end
        if (!is_store && got != int'(cur.cnt)) begin
            other_errs++;
            $display("instr %0d: feed ended after %0d of %0d words", tnum, got, cur.cnt);
        end
    endtask

    initial begin
        // op, start_x, start_y, elem_cnt, byte_addr, count
        tests[0]  = '{lsu_pkg::OP_ST_IRAM,   4'd0, 4'd0,  5'd16, 12'h000, 8'd16};
        tests[1]  = '{lsu_pkg::OP_FEED_IRAM, 4'd0, 4'd0,  5'd16, 12'h000, 8'd16};
        tests[2]  = '{lsu_pkg::OP_ST_WRAM,   4'd5, 4'd12, 5'd7,  12'h100, 8'd6};
        tests[3]  = '{lsu_pkg::OP_FEED_WRAM, 4'd0, 4'd0,  5'd16, 12'h100, 8'd6};
        tests[4]  = '{lsu_pkg::OP_ST_IRAM,   4'd0, 4'd3,  5'd16, 12'hFD0, 8'd8};
        tests[5]  = '{lsu_pkg::OP_FEED_IRAM, 4'd0, 4'd0,  5'd16, 12'hFD0, 8'd8};
        tests[6]  = '{lsu_pkg::OP_ST_IRAM,   4'd3, 4'd7,  5'd16, 12'h400, 8'd4};
        tests[7]  = '{lsu_pkg::OP_ST_WRAM,   4'd0, 4'd7,  5'd9,  12'h400, 8'd4};
        tests[8]  = '{lsu_pkg::OP_FEED_IRAM, 4'd0, 4'd0,  5'd16, 12'h400, 8'd4};
        tests[9]  = '{lsu_pkg::OP_FEED_WRAM, 4'd0, 4'd0,  5'd16, 12'h400, 8'd4};
        tests[10] = '{lsu_pkg::OP_ST_IRAM,   4'd2, 4'd9,  5'd12, 12'h80C, 8'd16};
        tests[11] = '{lsu_pkg::OP_FEED_IRAM, 4'd0, 4'd0,  5'd16, 12'hFD0, 8'd19};
        tests[12] = '{lsu_pkg::OP_FEED_IRAM, 4'd0, 4'd0,  5'd16, 12'h800, 8'd16};
        rst_n        <= 1'b0;
        instr_vld    <= 1'b0;
        op           <= lsu_pkg::OP_ST_IRAM;
        start_x      <= '0;
        start_y      <= '0;
        elem_cnt     <= '0;
        byte_addr    <= '0;
        count        <= '0;
        mxu_rows     <= '0;
        mxu_data_rdy <= 1'b0;
        feed_rdy     <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks += 2;
        if (instr_rdy !== 1'b1) begin
            mismatches++;
            $display("MISMATCH instr_rdy after reset: got %h expected 1", instr_rdy);
        end
        if (feed_vld !== 1'b0) begin
            mismatches++;
            $display("MISMATCH feed_vld after reset: got %h expected 0", feed_vld);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_instr(tests[t], t);
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: instructions did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_sva.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  instr_rdy,
    input lsu_pkg::ctrl_state_e  state,
    input logic                  feed_vld,
    input logic                  feed_rdy,
    input lsu_pkg::row_t         feed_data,
    input logic                  iram_ce,
    input logic                  iram_we,
    input logic                  wram_ce,
    input logic                  wram_we
);

    // a stalled feed word stays put until the matrix unit takes it
    feed_hold: assert property (@(posedge clk) disable iff (!rst_n)
        feed_vld && !feed_rdy |=> feed_vld && $stable(feed_data))
        else $error("feed output moved while feed_rdy was low");

    one_ram: assert property (@(posedge clk) disable iff (!rst_n) !(iram_ce && wram_ce))
        else $error("iram and wram enabled in the same cycle");

    rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
        instr_rdy == (state == lsu_pkg::ST_IDLE))
        else $error("instr_rdy does not track the idle state");

    // write enable only together with chip enable
    we_iram: assert property (@(posedge clk) disable iff (!rst_n) !(iram_we && !iram_ce))
        else $error("iram we high without ce");
    we_wram: assert property (@(posedge clk) disable iff (!rst_n) !(wram_we && !wram_ce))
        else $error("wram we high without ce");

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/1ns
`default_nettype none

module lsu (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_vld,
    output logic                             instr_rdy,
    input  lsu_pkg::lsu_op_e                 op,
    input  logic [3:0]                       start_x,
    input  logic [lsu_pkg::ROW_IDX_W-1:0]    start_y,
    input  logic [lsu_pkg::ELEM_CNT_W-1:0]   elem_cnt,
    input  logic [lsu_pkg::BYTE_ADDR_W-1:0]  byte_addr,
    input  logic [lsu_pkg::COUNT_W-1:0]      count,
    input  lsu_pkg::row_bank_t               mxu_rows,
    input  logic                             mxu_data_rdy,
    output logic                             feed_vld,
    input  logic                             feed_rdy,
    output lsu_pkg::row_t                    feed_data
);

    logic [lsu_pkg::ROW_IDX_W-1:0]   row_sel;
    logic [3:0]                      win_start;
    logic [lsu_pkg::ELEM_CNT_W-1:0]  win_cnt;
    lsu_pkg::row_t                   store_word;

    sram_if iram_bus ();
    sram_if wram_bus ();

    lsu_ctrl ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_vld    (instr_vld),
        .instr_rdy    (instr_rdy),
        .op           (op),
        .start_x      (start_x),
        .start_y      (start_y),
        .elem_cnt     (elem_cnt),
        .byte_addr    (byte_addr),
        .count        (count),
        .mxu_data_rdy (mxu_data_rdy),
        .row_sel      (row_sel),
        .win_start    (win_start),
        .win_cnt      (win_cnt),
        .iram_port    (iram_bus.master),
        .wram_port    (wram_bus.master),
        .feed_vld     (feed_vld),
        .feed_rdy     (feed_rdy),
        .feed_data    (feed_data)
    );

    row_extract extract (
        .mxu_rows (mxu_rows),
        .row_sel  (row_sel),
        .start_x  (win_start),
        .elem_cnt (win_cnt),
        .word     (store_word)
    );

    // masked row goes to both scratchpads, ce picks the target
    assign iram_bus.din = store_word;
    assign wram_bus.din = store_word;

    scratchpad_ram iram (
        .clk  (clk),
        .port (iram_bus.memory)
    );

    scratchpad_ram wram (
        .clk  (clk),
        .port (wram_bus.memory)
    );

endmodule

`default_nettype wire

//--- lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_vld,
    output logic                             instr_rdy,
    input  lsu_pkg::lsu_op_e                 op,
    input  logic [3:0]                       start_x,
    input  logic [lsu_pkg::ROW_IDX_W-1:0]    start_y,
    input  logic [lsu_pkg::ELEM_CNT_W-1:0]   elem_cnt,
    input  logic [lsu_pkg::BYTE_ADDR_W-1:0]  byte_addr,
    input  logic [lsu_pkg::COUNT_W-1:0]      count,
    input  logic                             mxu_data_rdy,
    output logic [lsu_pkg::ROW_IDX_W-1:0]    row_sel,
    output logic [3:0]                       win_start,
    output logic [lsu_pkg::ELEM_CNT_W-1:0]   win_cnt,
    sram_if.master                           iram_port,
    sram_if.master                           wram_port,
    output logic                             feed_vld,
    input  logic                             feed_rdy,
    output lsu_pkg::row_t                    feed_data
);

    lsu_pkg::ctrl_state_e            state;
    lsu_pkg::lsu_op_e                op_q;
    logic [lsu_pkg::RAM_ADDR_W-1:0]  addr_cnt;
    logic [lsu_pkg::COUNT_W-1:0]     remain;
    logic                            rd_issued;
    logic                            accept;
    logic                            to_wram;
    logic                            store_wr;
    logic                            feed_rd;
    logic                            last_word;
    logic                            port_ce;

    assign instr_rdy = (state == lsu_pkg::ST_IDLE);
    assign accept    = instr_vld & instr_rdy;
    assign to_wram   = (op_q == lsu_pkg::OP_ST_WRAM) || (op_q == lsu_pkg::OP_FEED_WRAM);

    // one store write per cycle the result bank is ready
    assign store_wr  = (state == lsu_pkg::ST_STORE) & mxu_data_rdy;
    // read goes out in the first cycle of ST_FEED_RD only
    assign feed_rd   = (state == lsu_pkg::ST_FEED_RD) & ~rd_issued;
    assign last_word = (remain == 'd1);
    assign port_ce   = store_wr | feed_rd;

    // only the scratchpad named by the opcode sees ce and we
    assign iram_port.ce   = port_ce & ~to_wram;
    assign iram_port.we   = store_wr & ~to_wram;
    assign iram_port.addr = addr_cnt;
    assign wram_port.ce   = port_ce & to_wram;
    assign wram_port.we   = store_wr & to_wram;
    assign wram_port.addr = addr_cnt;

    assign feed_vld = (state == lsu_pkg::ST_FEED_OUT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lsu_pkg::ST_IDLE;
            op_q      <= lsu_pkg::OP_ST_IRAM;
            row_sel   <= '0;
            addr_cnt  <= '0;
            remain    <= '0;
            win_start <= '0;
            win_cnt   <= '0;
            rd_issued <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::ST_IDLE: begin
                    if (accept) begin
                        op_q      <= op;
                        win_start <= start_x;
                        win_cnt   <= elem_cnt;
                        row_sel   <= start_y;
                        // word address is the upper part of the byte address
                        addr_cnt  <= byte_addr[lsu_pkg::BYTE_ADDR_W-1 -: lsu_pkg::RAM_ADDR_W];
                        remain    <= count;
                        rd_issued <= 1'b0;
                        if (op inside {lsu_pkg::OP_ST_IRAM, lsu_pkg::OP_ST_WRAM}) begin
                            state <= lsu_pkg::ST_STORE;
                        end else begin
                            state <= lsu_pkg::ST_FEED_RD;
                        end
                    end
                end
                lsu_pkg::ST_STORE: begin
                    if (mxu_data_rdy) begin
                        // both counters wrap by width
                        row_sel  <= row_sel + 1'b1;
                        addr_cnt <= addr_cnt + 1'b1;
                        remain   <= remain - 1'b1;
                        if (last_word) begin
                            state <= lsu_pkg::ST_IDLE;
                        end
                    end
                end
                lsu_pkg::ST_FEED_RD: begin
                    if (!rd_issued) begin
                        rd_issued <= 1'b1;
                    end else begin
                        // dout is valid now and lands in feed_data this edge
                        rd_issued <= 1'b0;
                        addr_cnt  <= addr_cnt + 1'b1;
                        state     <= lsu_pkg::ST_FEED_OUT;
                    end
                end
                lsu_pkg::ST_FEED_OUT: begin
                    if (feed_rdy) begin
                        remain <= remain - 1'b1;
                        if (last_word) begin
                            state <= lsu_pkg::ST_IDLE;
                        end else begin
                            state <= lsu_pkg::ST_FEED_RD;
                        end
                    end
                end
                default: state <= lsu_pkg::ST_IDLE;
            endcase
        end
    end

    // feed output register, held while the matrix unit stalls
    always_ff @(posedge clk) begin
        if ((state == lsu_pkg::ST_FEED_RD) && rd_issued) begin
            feed_data <= to_wram ? wram_port.dout : iram_port.dout;
        end
    end

endmodule

`default_nettype wire

//--- row_extract.sv
`timescale 1ns/1ns
`default_nettype none

module row_extract (
    input  lsu_pkg::row_bank_t               mxu_rows,
    input  logic [lsu_pkg::ROW_IDX_W-1:0]    row_sel,
    input  logic [3:0]                       start_x,
    input  logic [lsu_pkg::ELEM_CNT_W-1:0]   elem_cnt,
    output lsu_pkg::row_t                    word
);

    lsu_pkg::row_t row_raw;
    lsu_pkg::row_t row_shift;

    assign row_raw = mxu_rows[row_sel];

    // drop start_x elements off the low end; zero fill covers columns past 15
    assign row_shift = row_raw >> (start_x * lsu_pkg::ELEM_W);

    // keep only the first elem_cnt elements of the window
    always_comb begin
        for (int i = 0; i < lsu_pkg::ROW_ELEMS; i++) begin
            if (i < elem_cnt) begin
                word[i*lsu_pkg::ELEM_W +: lsu_pkg::ELEM_W] =
                    row_shift[i*lsu_pkg::ELEM_W +: lsu_pkg::ELEM_W];
            end else begin
                word[i*lsu_pkg::ELEM_W +: lsu_pkg::ELEM_W] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- scratchpad_ram.sv
`timescale 1ns/1ns
`default_nettype none

module scratchpad_ram (
    input logic     clk,
    sram_if.memory  port
);

    lsu_pkg::row_t mem [lsu_pkg::RAM_DEPTH];

    // single port, write wins; read data shows up one cycle later
    always_ff @(posedge clk) begin
        if (port.ce) begin
            if (port.we) begin
                mem[port.addr] <= port.din;
            end else begin
                port.dout <= mem[port.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- sram_if.sv
`timescale 1ns/1ns
`default_nettype none

// one single-port scratchpad port
interface sram_if;

    logic                            ce;
    logic                            we;
    logic [lsu_pkg::RAM_ADDR_W-1:0]  addr;
    lsu_pkg::row_t                   din;
    lsu_pkg::row_t                   dout;

    // control side, write data is hooked up separately at the top
    modport master (
        output ce,
        output we,
        output addr,
        input  dout
    );

    modport memory (
        input  ce,
        input  we,
        input  addr,
        input  din,
        output dout
    );

endinterface

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // int8 result rows from the matrix unit
    localparam int ELEM_W     = 8;
    localparam int ROW_ELEMS  = 16;
    localparam int ROW_W      = ELEM_W * ROW_ELEMS;
    localparam int NUM_ROWS   = 16;
    localparam int ROW_IDX_W  = 4;

    // scratchpad geometry, one row per word
    localparam int RAM_DEPTH  = 256;
    localparam int RAM_ADDR_W = 8;

    // instruction fields
    localparam int BYTE_ADDR_W = 12;
    localparam int COUNT_W     = 8;
    // element count runs 1..16, so one extra bit
    localparam int ELEM_CNT_W  = 5;

    typedef logic [ROW_W-1:0] row_t;

    // element 0 of a row sits in the low byte
    typedef row_t [NUM_ROWS-1:0] row_bank_t;

    typedef enum logic [1:0] {
        OP_ST_IRAM   = 2'd0,
        OP_ST_WRAM   = 2'd1,
        OP_FEED_IRAM = 2'd2,
        OP_FEED_WRAM = 2'd3
    } lsu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_STORE    = 2'd1,
        ST_FEED_RD  = 2'd2,
        ST_FEED_OUT = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire
